//--- wolf_soc_pkg.sv
// Shared definitions for the peripheral bus.
// Region code is the top REGION_W bits of the byte address.
// Peripheral offsets are word offsets taken from address bits [OFFSET_W+1:2].
// Bus logic is written for exactly two masters with a one-bit tag.
package wolf_soc_pkg;

   // ********************
   // Bus widths
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;
   localparam int NUM_MASTERS = 2;
   localparam int ID_W        = 1;
   localparam int REGION_W    = 4;
   localparam int OFFSET_W    = 8;

   // ********************
   // Address map
   localparam logic [REGION_W-1:0] REGION_RAM  = 4'd0;
   localparam logic [REGION_W-1:0] REGION_SYS  = 4'd1;
   localparam logic [REGION_W-1:0] REGION_GPIO = 4'd2;

   localparam int RAM_WORDS = 256;

   // System controller word offsets
   localparam logic [OFFSET_W-1:0] REG_SYS_TIMER  = 8'd0;
   localparam logic [OFFSET_W-1:0] REG_SYS_CMP    = 8'd1;
   localparam logic [OFFSET_W-1:0] REG_SYS_SWIRQ  = 8'd2;
   localparam logic [OFFSET_W-1:0] REG_SYS_STATUS = 8'd3;
   localparam int                  SW_IRQ_W       = 2;

   // GPIO word offsets
   localparam logic [OFFSET_W-1:0] REG_GPIO_OUT = 8'd0;
   localparam logic [OFFSET_W-1:0] REG_GPIO_DIR = 8'd1;
   localparam logic [OFFSET_W-1:0] REG_GPIO_IN  = 8'd2;
   localparam int                  GPIO_W       = 8;

   // One request on the shared bus
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [ID_W-1:0]   id;
   } bus_req_t;

endpackage

//--- soc_bus_if.sv
// Shared bus between arbiter and decoder, and one port per slave.
// No ready toward the decoder: every slave takes a request each cycle.
`timescale 1ns/1ps

interface soc_bus_if;
   import wolf_soc_pkg::*;

   logic              req_valid;
   bus_req_t          req;
   logic              rsp_valid;
   logic [DATA_W-1:0] rsp_rdata;
   logic              rsp_err;
   logic [ID_W-1:0]   rsp_id;

   modport arb (output req_valid, req, input rsp_valid, rsp_rdata, rsp_err, rsp_id);
   modport dec (input req_valid, req, output rsp_valid, rsp_rdata, rsp_err, rsp_id);
endinterface

interface periph_if;
   import wolf_soc_pkg::*;

   logic                sel;
   logic                we;
   logic [OFFSET_W-1:0] offset;
   logic [DATA_W-1:0]   wdata;
   logic [DATA_W-1:0]   rdata;

   modport host  (output sel, we, offset, wdata, input rdata);
   modport slave (input sel, we, offset, wdata, output rdata);
endinterface

//--- bus_arbiter.sv
// Round-robin arbiter for two masters onto the shared bus.
// Ready is combinational from valid; a master must hold its request until taken.
// The granted request appears on the bus one edge after acceptance.
// The tag in each request must already hold the master index.
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                                                   clk,
   input  logic                                                   i_rst_n,
   input  logic [wolf_soc_pkg::NUM_MASTERS-1:0]                   i_valid,
   input  wolf_soc_pkg::bus_req_t [wolf_soc_pkg::NUM_MASTERS-1:0] i_req,
   output logic [wolf_soc_pkg::NUM_MASTERS-1:0]                   o_ready,
   soc_bus_if.arb                                                 bus,
   output logic [wolf_soc_pkg::NUM_MASTERS-1:0]                   o_rsp_valid,
   output logic [wolf_soc_pkg::NUM_MASTERS-1:0][wolf_soc_pkg::DATA_W-1:0] o_rdata,
   output logic [wolf_soc_pkg::NUM_MASTERS-1:0]                   o_rsp_err
);
   import wolf_soc_pkg::*;

   logic [NUM_MASTERS-1:0] grant;
   logic [ID_W-1:0]        win_id;
   // Master granted most recently
   logic [ID_W-1:0]        last_grant;

   // ********************
   // Grant
   always_comb begin
      grant = i_valid;
      if (&i_valid) begin
         grant = '0;
         if (last_grant == ID_W'(1))
            grant[0] = 1'b1;
         else
            grant[1] = 1'b1;
      end
   end

   assign win_id  = ID_W'(grant[1]);
   assign o_ready = grant;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         last_grant    <= ID_W'(1);
         bus.req_valid <= 1'b0;
      end else begin
         bus.req_valid <= |grant;
         if (|grant)
            last_grant <= win_id;
      end
   end

   always_ff @(posedge clk) begin
      if (|grant)
         bus.req <= i_req[win_id];
   end

   // ********************
   // Response steering by tag
   always_comb begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
         o_rsp_valid[m] = bus.rsp_valid && (bus.rsp_id == ID_W'(m));
         o_rdata[m]     = bus.rsp_rdata;
         o_rsp_err[m]   = bus.rsp_err;
      end
   end

endmodule

//--- bus_decoder.sv
// Address decoder with one-cycle response path.
// Slaves sample the request on the edge after it reaches the bus; the
// response is valid for the following cycle. Unmapped regions give err
// with rdata 0 and select no slave.
`timescale 1ns/1ps

module bus_decoder (
   input  logic     clk,
   input  logic     i_rst_n,
   soc_bus_if.dec   bus,
   periph_if.host   ram,
   periph_if.host   sys,
   periph_if.host   gpio
);
   import wolf_soc_pkg::*;

   logic [REGION_W-1:0] region;
   logic [OFFSET_W-1:0] offset;
   logic                mapped;
   logic [REGION_W-1:0] region_q;
   logic                err_q;

   assign region = bus.req.addr[ADDR_W-1 -: REGION_W];
   assign offset = bus.req.addr[OFFSET_W+1:2];
   assign mapped = (region == REGION_RAM) || (region == REGION_SYS) ||
                   (region == REGION_GPIO);

   // ********************
   // Slave selects
   assign ram.sel     = bus.req_valid && (region == REGION_RAM);
   assign ram.we      = bus.req.we;
   assign ram.offset  = offset;
   assign ram.wdata   = bus.req.wdata;
   assign sys.sel     = bus.req_valid && (region == REGION_SYS);
   assign sys.we      = bus.req.we;
   assign sys.offset  = offset;
   assign sys.wdata   = bus.req.wdata;
   assign gpio.sel    = bus.req_valid && (region == REGION_GPIO);
   assign gpio.we     = bus.req.we;
   assign gpio.offset = offset;
   assign gpio.wdata  = bus.req.wdata;

   always_ff @(posedge clk) begin
      if (!i_rst_n)
         bus.rsp_valid <= 1'b0;
      else
         bus.rsp_valid <= bus.req_valid;
   end

   always_ff @(posedge clk) begin
      bus.rsp_id <= bus.req.id;
      region_q   <= region;
      err_q      <= !mapped;
   end

   // ********************
   // Response mux
   always_comb begin
      case (region_q)
         REGION_RAM:  bus.rsp_rdata = ram.rdata;
         REGION_SYS:  bus.rsp_rdata = sys.rdata;
         REGION_GPIO: bus.rsp_rdata = gpio.rdata;
         default:     bus.rsp_rdata = '0;
      endcase
   end

   assign bus.rsp_err = err_q;

endmodule

//--- sram_block.sv
// Word-addressed RAM slave, RAM_WORDS deep, no reset on contents.
// Read data is registered on every select, so a write returns the
// word held before the write.
`timescale 1ns/1ps

module sram_block (
   input  logic     clk,
   periph_if.slave  port
);
   import wolf_soc_pkg::*;

   localparam int IDX_W = $clog2(RAM_WORDS);

   logic [DATA_W-1:0] mem [RAM_WORDS];
   logic [IDX_W-1:0]  idx;

   assign idx = port.offset[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (port.sel && port.we)
         mem[idx] <= port.wdata;
   end

   // Registered read port
   always_ff @(posedge clk) begin
      if (port.sel)
         port.rdata <= mem[idx];
   end

endmodule

//--- sys_ctrl.sv
// System controller: free-running timer, compare interrupt, software
// interrupt bits and a status word with the RAM init inputs.
// Timer and status are read-only. Init inputs must be synchronous to clk.
// Reads are registered; a write returns the register value before the write.
`timescale 1ns/1ps

module sys_ctrl (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   periph_if.slave                              port,
   input  logic                                 i_ram_init_done,
   input  logic                                 i_ram_init_error,
   output logic                                 o_timer_irq,
   output logic [wolf_soc_pkg::SW_IRQ_W-1:0]    o_sw_irq
);
   import wolf_soc_pkg::*;

   logic [DATA_W-1:0] timer;
   logic [DATA_W-1:0] cmp;
   logic [DATA_W-1:0] status;

   assign status = {{(DATA_W-2){1'b0}}, i_ram_init_error, i_ram_init_done};

   // ********************
   // Timer and writable registers
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         timer       <= '0;
         cmp         <= '0;
         o_sw_irq    <= '0;
         o_timer_irq <= 1'b0;
      end else begin
         timer       <= timer + 1'b1;
         // Zero compare disables the interrupt
         o_timer_irq <= (cmp != '0) && (timer >= cmp);
         if (port.sel && port.we) begin
            case (port.offset)
               REG_SYS_CMP:   cmp      <= port.wdata;
               REG_SYS_SWIRQ: o_sw_irq <= port.wdata[SW_IRQ_W-1:0];
               default:       ;
            endcase
         end
      end
   end

   // Read copy
   always_ff @(posedge clk) begin
      if (port.sel) begin
         case (port.offset)
            REG_SYS_TIMER:  port.rdata <= timer;
            REG_SYS_CMP:    port.rdata <= cmp;
            REG_SYS_SWIRQ:  port.rdata <= DATA_W'(o_sw_irq);
            REG_SYS_STATUS: port.rdata <= status;
            default:        port.rdata <= '0;
         endcase
      end
   end

endmodule

//--- gpio_port.sv
// GPIO block with output and direction registers.
// Pin inputs pass a two-flop synchronizer, so a read of the input
// register sees pins as they were at least two cycles earlier.
`timescale 1ns/1ps

module gpio_port (
   input  logic                              clk,
   input  logic                              i_rst_n,
   periph_if.slave                           port,
   input  logic [wolf_soc_pkg::GPIO_W-1:0]   i_gpio_in,
   output logic [wolf_soc_pkg::GPIO_W-1:0]   o_gpio_out,
   output logic [wolf_soc_pkg::GPIO_W-1:0]   o_gpio_oe
);
   import wolf_soc_pkg::*;

   logic [GPIO_W-1:0] in_meta;
   logic [GPIO_W-1:0] in_sync;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
      end else if (port.sel && port.we) begin
         case (port.offset)
            REG_GPIO_OUT: o_gpio_out <= port.wdata[GPIO_W-1:0];
            REG_GPIO_DIR: o_gpio_oe  <= port.wdata[GPIO_W-1:0];
            default:      ;
         endcase
      end
   end

   // Pin synchronizer
   always_ff @(posedge clk) begin
      in_meta <= i_gpio_in;
      in_sync <= in_meta;
   end

   always_ff @(posedge clk) begin
      if (port.sel) begin
         case (port.offset)
            REG_GPIO_OUT: port.rdata <= DATA_W'(o_gpio_out);
            REG_GPIO_DIR: port.rdata <= DATA_W'(o_gpio_oe);
            REG_GPIO_IN:  port.rdata <= DATA_W'(in_sync);
            default:      port.rdata <= '0;
         endcase
      end
   end

endmodule

//--- wolf_soc_top.sv
// Bus subsystem top: two masters, arbiter, decoder and three slaves.
// A request accepted on one edge is answered in the cycle that ends two
// edges later. Masters must hold valid and fields until ready.
`timescale 1ns/1ps

module wolf_soc_top (
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_m0_valid,
   input  logic                                i_m0_we,
   input  logic [wolf_soc_pkg::ADDR_W-1:0]     i_m0_addr,
   input  logic [wolf_soc_pkg::DATA_W-1:0]     i_m0_wdata,
   output logic                                o_m0_ready,
   output logic                                o_m0_rsp_valid,
   output logic [wolf_soc_pkg::DATA_W-1:0]     o_m0_rdata,
   output logic                                o_m0_rsp_err,
   input  logic                                i_m1_valid,
   input  logic                                i_m1_we,
   input  logic [wolf_soc_pkg::ADDR_W-1:0]     i_m1_addr,
   input  logic [wolf_soc_pkg::DATA_W-1:0]     i_m1_wdata,
   output logic                                o_m1_ready,
   output logic                                o_m1_rsp_valid,
   output logic [wolf_soc_pkg::DATA_W-1:0]     o_m1_rdata,
   output logic                                o_m1_rsp_err,
   input  logic                                i_ram_init_done,
   input  logic                                i_ram_init_error,
   input  logic [wolf_soc_pkg::GPIO_W-1:0]     i_gpio_in,
   output logic [wolf_soc_pkg::GPIO_W-1:0]     o_gpio_out,
   output logic [wolf_soc_pkg::GPIO_W-1:0]     o_gpio_oe,
   output logic                                o_timer_irq,
   output logic [wolf_soc_pkg::SW_IRQ_W-1:0]   o_sw_irq
);
   import wolf_soc_pkg::*;

   bus_req_t m0_req;
   bus_req_t m1_req;

   // Master index becomes the response tag
   assign m0_req = '{we: i_m0_we, addr: i_m0_addr, wdata: i_m0_wdata, id: ID_W'(0)};
   assign m1_req = '{we: i_m1_we, addr: i_m1_addr, wdata: i_m1_wdata, id: ID_W'(1)};

   soc_bus_if bus ();
   periph_if  ram_port ();
   periph_if  sys_port ();
   periph_if  gpio_port_if ();

   bus_arbiter u_arbiter (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     ({i_m1_valid, i_m0_valid}),
      .i_req       ({m1_req, m0_req}),
      .o_ready     ({o_m1_ready, o_m0_ready}),
      .bus         (bus.arb),
      .o_rsp_valid ({o_m1_rsp_valid, o_m0_rsp_valid}),
      .o_rdata     ({o_m1_rdata, o_m0_rdata}),
      .o_rsp_err   ({o_m1_rsp_err, o_m0_rsp_err})
   );

   bus_decoder u_decoder (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .bus     (bus.dec),
      .ram     (ram_port.host),
      .sys     (sys_port.host),
      .gpio    (gpio_port_if.host)
   );

   sram_block u_ram (
      .clk  (clk),
      .port (ram_port.slave)
   );

   sys_ctrl u_sys (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .port             (sys_port.slave),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq         (o_sw_irq)
   );

   gpio_port u_gpio (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .port       (gpio_port_if.slave),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe)
   );

endmodule

//--- wolf_soc_asserts.sv
// Concurrent checks on the arbiter, bound into every bus_arbiter.
// Assumes masters hold valid until accepted, as the bus requires.
// fail_count lets the testbench fold these failures into its result.
`timescale 1ns/1ps

module wolf_soc_asserts (
   input logic                                 clk,
   input logic                                 i_rst_n,
   input logic [wolf_soc_pkg::NUM_MASTERS-1:0] i_valid,
   input logic [wolf_soc_pkg::NUM_MASTERS-1:0] i_ready,
   input logic [wolf_soc_pkg::NUM_MASTERS-1:0] i_rsp_valid
);
   import wolf_soc_pkg::*;

   int fail_count = 0;

   // At most one grant per cycle
   a_one_ready: assert property (@(posedge clk) disable iff (!i_rst_n) $onehot0(i_ready))
      else begin
         fail_count++;
         $error("more than one master granted in the same cycle");
      end

   for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
      // Response two edges after acceptance
      a_rsp_delay: assert property (@(posedge clk) disable iff (!i_rst_n)
            i_valid[m] && i_ready[m] |-> ##2 i_rsp_valid[m])
         else begin
            fail_count++;
            $error("master %0d response not two cycles after acceptance", m);
         end

      // Waiting master wins on the next edge
      a_grant_wait: assert property (@(posedge clk) disable iff (!i_rst_n)
            i_valid[m] && !i_ready[m] |=> i_ready[m])
         else begin
            fail_count++;
            $error("master %0d held valid without a grant", m);
         end
   end

endmodule

bind bus_arbiter wolf_soc_asserts u_asserts (
   .clk         (clk),
   .i_rst_n     (i_rst_n),
   .i_valid     (i_valid),
   .i_ready     (o_ready),
   .i_rsp_valid (o_rsp_valid)
);

//--- tb_wolf_soc.sv
// Testbench for the bus subsystem, driven from wolf_soc_stimulus.txt.
// Each master presents its own queue with 0 to 3 idle cycles before each request.
// Responses are checked per master in request order; rdata only on reads.
// Run from the project root so the stimulus file is found.
`timescale 1ns/1ps

module tb_wolf_soc;
   import wolf_soc_pkg::*;

   localparam int STIM_WORDS = 512;

   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W-1:0] exp_rdata;
      logic              exp_err;
      logic [1:0]        idle;
   } txn_t;

   logic                clk;
   logic                i_rst_n;
   logic                m_valid   [NUM_MASTERS];
   logic                m_we      [NUM_MASTERS];
   logic [ADDR_W-1:0]   m_addr    [NUM_MASTERS];
   logic [DATA_W-1:0]   m_wdata   [NUM_MASTERS];
   logic                m_ready   [NUM_MASTERS];
   logic                rsp_valid [NUM_MASTERS];
   logic [DATA_W-1:0]   rsp_rdata [NUM_MASTERS];
   logic                rsp_err   [NUM_MASTERS];
   logic                ram_init_done;
   logic                ram_init_error;
   logic [GPIO_W-1:0]   gpio_in;
   logic [GPIO_W-1:0]   gpio_out;
   logic [GPIO_W-1:0]   gpio_oe;
   logic                timer_irq;
   logic [SW_IRQ_W-1:0] sw_irq;

   logic [DATA_W-1:0] stim [STIM_WORDS];
   txn_t              q_drive0 [$];
   txn_t              q_drive1 [$];
   txn_t              q_exp0 [$];
   txn_t              q_exp1 [$];
   logic [15:0]       lfsr;
   logic [DATA_W-1:0] cmp_last = '0;
   int                limit = 100;
   int                cycles = 0;
   int                checked = 0;
   int                mismatches = 0;
   int                other_errors = 0;
   int                assert_fails = 0;
   int                irq_wait = 0;

   wolf_soc_top i_wolf_soc_top (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_m0_valid       (m_valid[0]),
      .i_m0_we          (m_we[0]),
      .i_m0_addr        (m_addr[0]),
      .i_m0_wdata       (m_wdata[0]),
      .o_m0_ready       (m_ready[0]),
      .o_m0_rsp_valid   (rsp_valid[0]),
      .o_m0_rdata       (rsp_rdata[0]),
      .o_m0_rsp_err     (rsp_err[0]),
      .i_m1_valid       (m_valid[1]),
      .i_m1_we          (m_we[1]),
      .i_m1_addr        (m_addr[1]),
      .i_m1_wdata       (m_wdata[1]),
      .o_m1_ready       (m_ready[1]),
      .o_m1_rsp_valid   (rsp_valid[1]),
      .o_m1_rdata       (rsp_rdata[1]),
      .o_m1_rsp_err     (rsp_err[1]),
      .i_ram_init_done  (ram_init_done),
      .i_ram_init_error (ram_init_error),
      .i_gpio_in        (gpio_in),
      .o_gpio_out       (gpio_out),
      .o_gpio_oe        (gpio_oe),
      .o_timer_irq      (timer_irq),
      .o_sw_irq         (sw_irq)
   );

   always #5 clk = ~clk;

   // ********************
   // Helpers
   function automatic logic take_bit();
      take_bit = lfsr[0];
      lfsr     = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input logic [REGION_W-1:0] region,
                                                  input logic [OFFSET_W-1:0] offset);
      reg_addr = {region, {(ADDR_W-REGION_W-OFFSET_W-2){1'b0}}, offset, 2'b00};
   endfunction

   task automatic report_mismatch(input string what, input logic [DATA_W-1:0] got,
                                  input logic [DATA_W-1:0] exp);
      mismatches++;
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, what, got, exp);
   endtask

   task automatic load_stimulus();
      int   pos;
      int   n;
      txn_t t;
      logic b0;
      logic b1;
      $readmemh("wolf_soc_stimulus.txt", stim);
      gpio_in        = stim[0][GPIO_W-1:0];
      ram_init_done  = stim[1][0];
      ram_init_error = stim[2][0];
      pos = 3;
      n   = 0;
      // Master column above 1 ends the list
      while (pos + 5 < STIM_WORDS && stim[pos] < 2) begin
         b0          = take_bit();
         b1          = take_bit();
         t.we        = stim[pos+1][0];
         t.addr      = stim[pos+2][ADDR_W-1:0];
         t.wdata     = stim[pos+3];
         t.exp_rdata = stim[pos+4];
         t.exp_err   = stim[pos+5][0];
         t.idle      = {b1, b0};
         if (stim[pos] == 0) begin
            q_drive0.push_back(t);
            q_exp0.push_back(t);
         end else begin
            q_drive1.push_back(t);
            q_exp1.push_back(t);
         end
         n++;
         pos += 6;
      end
      limit = 8 * n + 100;
   endtask

   task automatic drive_master(input int m);
      txn_t t;
      while ((m == 0 && q_drive0.size() != 0) || (m == 1 && q_drive1.size() != 0)) begin
         if (m == 0)
            t = q_drive0.pop_front();
         else
            t = q_drive1.pop_front();
         repeat (t.idle) begin
            m_valid[m] <= 1'b0;
            @(posedge clk);
         end
         m_valid[m] <= 1'b1;
         m_we[m]    <= t.we;
         m_addr[m]  <= t.addr;
         m_wdata[m] <= t.wdata;
         // Ready sampled mid-cycle, acceptance on the next edge
         do
            @(negedge clk);
         while (!m_ready[m]);
         @(posedge clk);
      end
      m_valid[m] <= 1'b0;
   endtask

   task automatic check_write(input int m, input txn_t t);
      if (t.addr == reg_addr(REGION_SYS, REG_SYS_SWIRQ))
         assert (sw_irq == t.wdata[SW_IRQ_W-1:0])
            else report_mismatch("o_sw_irq", DATA_W'(sw_irq), t.wdata);
      if (t.addr == reg_addr(REGION_GPIO, REG_GPIO_OUT))
         assert (gpio_out == t.wdata[GPIO_W-1:0])
            else report_mismatch("o_gpio_out", DATA_W'(gpio_out), t.wdata);
      if (t.addr == reg_addr(REGION_GPIO, REG_GPIO_DIR))
         assert (gpio_oe == t.wdata[GPIO_W-1:0])
            else report_mismatch("o_gpio_oe", DATA_W'(gpio_oe), t.wdata);
      if (t.addr == reg_addr(REGION_SYS, REG_SYS_CMP)) begin
         // Interrupt still follows the previous compare value here
         if (cmp_last == '0)
            assert (!timer_irq)
               else report_mismatch("o_timer_irq", DATA_W'(timer_irq), '0);
         cmp_last = t.wdata;
         if (t.wdata != '0)
            irq_wait = int'(t.wdata) + 4;
      end
   endtask

   task automatic check_response(input int m);
      txn_t t;
      if ((m == 0 && q_exp0.size() == 0) || (m == 1 && q_exp1.size() == 0)) begin
         other_errors++;
         $display("ERROR at %0t: master %0d got a response it never asked for", $time, m);
      end else begin
         if (m == 0)
            t = q_exp0.pop_front();
         else
            t = q_exp1.pop_front();
         checked++;
         assert (rsp_err[m] == t.exp_err)
            else report_mismatch($sformatf("master %0d err at %h", m, t.addr),
                                 DATA_W'(rsp_err[m]), DATA_W'(t.exp_err));
         if (!t.we)
            assert (rsp_rdata[m] == t.exp_rdata)
               else report_mismatch($sformatf("master %0d read %h", m, t.addr),
                                    rsp_rdata[m], t.exp_rdata);
         else
            check_write(m, t);
      end
   endtask

   // ********************
   // Response checking
   always @(negedge clk) begin
      if (irq_wait > 0) begin
         if (timer_irq) begin
            irq_wait = 0;
         end else begin
            irq_wait = irq_wait - 1;
            assert (irq_wait > 0) else begin
               other_errors++;
               $display("ERROR at %0t: timer interrupt not raised after compare write", $time);
            end
         end
      end
      for (int m = 0; m < NUM_MASTERS; m++) begin
         if (i_rst_n && rsp_valid[m])
            check_response(m);
      end
   end

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("ERROR: timeout after %0d cycles with responses outstanding", cycles);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      clk     = 1'b0;
      i_rst_n = 1'b0;
      lfsr    = 16'd5;
      for (int m = 0; m < NUM_MASTERS; m++) begin
         m_valid[m] = 1'b0;
         m_we[m]    = 1'b0;
         m_addr[m]  = '0;
         m_wdata[m] = '0;
      end
      load_stimulus();
      repeat (5) @(posedge clk);
      i_rst_n <= 1'b1;
      fork
         drive_master(0);
         drive_master(1);
      join
      while (q_exp0.size() != 0 || q_exp1.size() != 0 || irq_wait != 0)
         @(posedge clk);
      @(posedge clk);
      assert_fails = i_wolf_soc_top.u_arbiter.u_asserts.fail_count;
      $display("Checked %0d responses: %0d mismatches, %0d other errors, %0d assertion failures",
               checked, mismatches, other_errors, assert_fails);
      if (mismatches == 0 && other_errors == 0 && assert_fails == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- wolf_soc_stimulus.txt
// Header: gpio_in init_done init_error
// Rows: master we addr wdata exp_rdata exp_err (exp_rdata unused on writes), master FF ends
A5 1 0
0 1 0000 11111111 00000000 0
1 1 0100 44444444 00000000 0
0 1 0004 22222222 00000000 0
1 1 0104 55555555 00000000 0
0 1 0010 33333333 00000000 0
1 0 0100 00000000 44444444 0
0 0 0000 00000000 11111111 0
1 0 0104 00000000 55555555 0
0 0 0004 00000000 22222222 0
1 1 2000 0000005A 00000000 0
0 1 3010 DEADBEEF 00000000 1
1 1 2004 000000F0 00000000 0
0 0 0010 00000000 33333333 0
1 0 2000 00000000 0000005A 0
0 0 F000 00000000 00000000 1
1 0 2008 00000000 000000A5 0
0 1 1008 00000003 00000000 0
1 1 1004 00000006 00000000 0
0 0 1008 00000000 00000003 0
1 0 1004 00000000 00000006 0
0 0 100C 00000000 00000001 0
1 0 7104 00000000 00000000 1
FF 0 0 0 0 0

//--- wolf_soc.f
wolf_soc_pkg.sv
soc_bus_if.sv
bus_arbiter.sv
bus_decoder.sv
sram_block.sv
sys_ctrl.sv
gpio_port.sv
wolf_soc_top.sv
wolf_soc_asserts.sv
tb_wolf_soc.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_wolf_soc
FILELIST  := wolf_soc.f
LOG       := sim.log
SHELL     := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	set -o pipefail; ./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
